/* verif/gps_cpu_stimulus.txt */
// gps_cpu boot image and expected register writes, all values hex
// layout: program length, program words, par, ser, write count, then one "sel bank data" per write
0061
// 00: literal push and write, both banks
1234 d001 7fff dfff
// 04: add, then add with carry
0000 8e00 0001 8800 d002 0005 0006 8840 d003
// 0d: sub, addi, mult
0100 0123 8900 d004
1000 877f d805
0100 0004 8e00 8a00 d006
// 19: and, or, not
0f0f 33cc 8b00 d007
0f0f 3030 8c00 d008
5555 8e00 d009
// 24: shl, shr, swap16
4001 9100 d00a
0010 8e00 9200 d00b
1234 8300 d80c
// 2e: rot swap over drop dup to_r r swap r_from
0011 0022 0033 8600 8200 8400 8500 8100 0044 9e00 9c00 8200 9d00
d010 d011 d012 d013 d014 d015
// 41: countdown loop with bnz to 42, then call to 5e
0003 8100 d020 0001 8900 8100 b085 8500
a0bc 0066 d022
// 4c: rd_reg, rd_bit from both banks
c030 d023
0001 9300 9340 d824
// 52: store16 then fetch16 at byte address 0f00
1543 8e00 0f00 9500 8100 d025 0f00 9400 d026 8500
// 5c: closing event, then spin in place
e3ff a0bb
// 5e: subroutine
0055 d021 8080
// par, ser
beef
2
// expected writes
1c
001 0 00001234
7ff 1 00007fff
002 0 00000000
003 0 0000000c
004 0 ffffffdd
005 1 0000107f
006 0 fffffb00
007 0 0000030c
008 0 00003f3f
009 0 ffffaaaa
00a 0 00008002
00b 0 fffffff7
00c 1 12340000
010 0 00000044
011 0 00000033
012 0 00000044
013 0 00000033
014 0 00000011
015 0 00000022
020 0 00000003
020 0 00000002
020 0 00000001
021 0 00000055
022 0 00000066
023 0 0000beef
024 1 00000005
025 0 00000f02
026 0 0000eabc

/* gps_cpu.f */
verilog/gps_cpu_io_pkg.sv
verilog/gps_cpu_isa_pkg.sv
verilog/gps_cpu_alu.sv
verilog/gps_cpu_stacks.sv
verilog/gps_cpu_code_ram.sv
verilog/gps_cpu_core.sv
verilog/gps_cpu_top.sv
verif/gps_cpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the gps_cpu testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module gps_cpu_tb \
    -Mdir "$build_dir" -f gps_cpu.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/Vgps_cpu_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Verification passed" "$log_file"; then
    echo "simulation result: pass"
    exit 0
else
    echo "simulation result: fail"
    exit 1
fi

/* verif/gps_cpu_tb.sv */
// gps_cpu testbench: boots a program over par, runs it and checks every register write
`timescale 1ns/1ps

module gps_cpu_tb;

    localparam int STIM_DEPTH = 512;
    // reset, release and first fetch around the load
    localparam int MARGIN_CYCLES = 8;
    localparam int CYCLES_PER_WRITE = 200;

    logic clk;
    logic arst_n;
    logic load;
    gps_cpu_io_pkg::half_t par;
    logic [1:0] ser;
    logic wr_reg;
    logic wr_evt;
    logic rd_reg;
    logic rd_bit;
    logic io_bank;
    logic [gps_cpu_io_pkg::IO_SEL_W-1:0] io_sel;
    gps_cpu_io_pkg::word_t io_data;

    // length, program, par, ser, write count, then sel/bank/data triples
    logic [31:0] stim [STIM_DEPTH];
    int prog_len;
    int exp_base;
    int exp_count;
    int exp_idx;
    int entry;
    int errors;
    int limit_cycles;
    logic evt_seen;
    // {wr_evt, rd_bit, rd_reg} one-hot, bank, select
    logic [14:0] strobe_exp [$];
    logic [14:0] strobe_next;

    gps_cpu_top #(.STACK_AW(8)) dut0 (
        .clk, .arst_n, .load, .par, .ser,
        .wr_reg, .wr_evt, .rd_reg, .rd_bit, .io_bank, .io_sel, .io_data
    );

    // 4 ns period
    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, expected);
        end
    endtask

    // one program word per cycle while load is high
    task automatic load_program();
        int i;
        for (i = 0; i < prog_len; i++) begin
            load <= 1'b1;
            par <= stim[1 + i][15:0];
            @(posedge clk);
        end
        load <= 1'b0;
        // par and ser stay constant for the whole run
        par <= stim[prog_len + 1][15:0];
        ser <= stim[prog_len + 2][1:0];
    endtask

    // read and event strobes decoded from the image, in program order
    task automatic collect_strobes();
        int i;
        logic [15:0] word;
        for (i = 0; i < prog_len; i++) begin
            word = stim[1 + i][15:0];
            if (word[15:12] == 4'hc) begin
                strobe_exp.push_back({3'b001, word[11:0]});
            end else if (word[15:8] == 8'h93) begin
                // bank from imm bit 6, no select
                strobe_exp.push_back({3'b010, word[6], 11'd0});
            end else if (word[15:12] == 4'he) begin
                strobe_exp.push_back({3'b100, word[11:0]});
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // register write monitor

    // strobes decode the registered insn and are stable at negedge
    always @(negedge clk) begin
        if (arst_n && wr_reg) begin
            if (exp_idx >= exp_count) begin
                errors++;
                $display("unexpected register write at %0t ns to select %h", $time, io_sel);
            end else begin
                entry = exp_base + 3 * exp_idx;
                check_value($sformatf("io_sel of write %0d", exp_idx),
                            32'(io_sel), stim[entry]);
                check_value($sformatf("io_bank of write %0d", exp_idx),
                            32'(io_bank), stim[entry + 1]);
                check_value($sformatf("io_data of write %0d", exp_idx),
                            io_data, stim[entry + 2]);
                exp_idx++;
            end
        end
        if (arst_n && (rd_reg || rd_bit || wr_evt)) begin
            if (strobe_exp.size() == 0) begin
                errors++;
                $display("unexpected read or event strobe at %0t ns", $time);
            end else begin
                strobe_next = strobe_exp.pop_front();
                check_value("strobe kind {wr_evt, rd_bit, rd_reg}",
                            32'({wr_evt, rd_bit, rd_reg}), 32'(strobe_next[14:12]));
                check_value("io_bank of strobe", 32'(io_bank), 32'(strobe_next[11]));
                if (!strobe_next[13]) begin
                    check_value("io_sel of strobe", 32'(io_sel), 32'(strobe_next[10:0]));
                end
            end
        end
        // closing event of the program
        if (arst_n && wr_evt) begin
            evt_seen = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        load = 1'b0;
        par = '0;
        ser = '0;
        errors = 0;
        exp_idx = 0;
        exp_count = 0;
        limit_cycles = 0;
        evt_seen = 1'b0;
        $readmemh("verif/gps_cpu_stimulus.txt", stim);
        if ($isunknown(stim[0])) begin
            errors++;
            $display("stimulus file could not be read or holds no program length");
        end else begin
            prog_len = int'(stim[0]);
            exp_count = int'(stim[prog_len + 3]);
            exp_base = prog_len + 4;
            limit_cycles = prog_len + CYCLES_PER_WRITE * exp_count + MARGIN_CYCLES;
            collect_strobes();
            // reset held for 2 cycles
            repeat (2) @(posedge clk);
            // load rises with the release, nothing runs from the empty RAM
            arst_n <= 1'b1;
            load_program();
            wait (evt_seen);
            @(posedge clk);
            // every expected write must have been seen
            check_value("expected writes left", 32'(exp_count - exp_idx), 32'd0);
            check_value("expected strobes left", 32'(strobe_exp.size()), 32'd0);
        end
        $display("errors: %0d, register writes checked: %0d of %0d",
                 errors, exp_idx, exp_count);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog armed once the test length is known
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: no closing event after %0d cycles", limit_cycles);
        $display("errors: %0d, register writes checked: %0d of %0d",
                 errors, exp_idx, exp_count);
        $display("Verification failed");
        $finish;
    end

endmodule

/* verilog/gps_cpu_top.sv */
// gps_cpu top: stack processor core with its ALU, stack RAM and code RAM
`timescale 1ns/1ps

module gps_cpu_top #(
    parameter int STACK_AW = 8
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 load,
    input  gps_cpu_io_pkg::half_t                par,
    input  logic [1:0]                           ser,
    output logic                                 wr_reg,
    output logic                                 wr_evt,
    output logic                                 rd_reg,
    output logic                                 rd_bit,
    output logic                                 io_bank,
    output logic [gps_cpu_io_pkg::IO_SEL_W-1:0]  io_sel,
    output gps_cpu_io_pkg::word_t                io_data
);

    gps_cpu_isa_pkg::insn_t insn;
    gps_cpu_io_pkg::word_t tos;
    gps_cpu_io_pkg::word_t nos;
    gps_cpu_io_pkg::word_t alu_result;
    gps_cpu_io_pkg::word_t dstk_top;
    gps_cpu_io_pkg::word_t rstk_top;
    gps_cpu_io_pkg::word_t rstk_din;
    gps_cpu_io_pkg::half_t mem_dout;
    gps_cpu_io_pkg::half_t mem_din;
    logic [gps_cpu_isa_pkg::CODE_AW-1:0] next_pc;
    logic [gps_cpu_isa_pkg::CODE_AW-1:0] mem_addr;
    logic mem_rd;
    logic mem_we;
    logic alu_en;
    logic dpush;
    logic dpop;
    logic rpush;
    logic rpop;

    gps_cpu_core #(.STACK_AW(STACK_AW)) core0 (
        .clk, .arst_n, .load, .insn, .mem_dout, .par, .ser,
        .alu_result, .dstk_top, .rstk_top, .tos, .nos, .mem_rd, .alu_en,
        .dpush, .dpop, .rpush, .rpop, .rstk_din, .next_pc,
        .mem_addr, .mem_we, .mem_din,
        .rd_reg, .rd_bit, .wr_reg, .wr_evt, .io_bank, .io_sel, .io_data
    );

    gps_cpu_alu alu0 (
        .clk, .arst_n, .alu_en, .insn, .tos, .nos, .mem_rd, .alu_result
    );

    // nos is what spills into the data stack
    gps_cpu_stacks #(.STACK_AW(STACK_AW)) stacks0 (
        .clk, .arst_n, .dpush, .dpop, .rpush, .rpop,
        .dstk_din(nos), .rstk_din, .dstk_top, .rstk_top
    );

    gps_cpu_code_ram code_ram0 (
        .clk, .arst_n, .load, .par, .next_pc,
        .mem_addr, .mem_we, .mem_din, .insn, .mem_dout
    );

endmodule

/* verilog/gps_cpu_core.sv */
// gps_cpu core: decode, program counter, top/next of stack and the I/O strobes
`timescale 1ns/1ps

module gps_cpu_core #(
    parameter int STACK_AW = 8
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 load,
    input  gps_cpu_isa_pkg::insn_t               insn,
    input  gps_cpu_io_pkg::half_t                mem_dout,
    input  gps_cpu_io_pkg::half_t                par,
    input  logic [1:0]                           ser,
    input  gps_cpu_io_pkg::word_t                alu_result,
    input  gps_cpu_io_pkg::word_t                dstk_top,
    input  gps_cpu_io_pkg::word_t                rstk_top,
    output gps_cpu_io_pkg::word_t                tos,
    output gps_cpu_io_pkg::word_t                nos,
    output logic                                 mem_rd,
    output logic                                 alu_en,
    output logic                                 dpush,
    output logic                                 dpop,
    output logic                                 rpush,
    output logic                                 rpop,
    output gps_cpu_io_pkg::word_t                rstk_din,
    output logic [gps_cpu_isa_pkg::CODE_AW-1:0]  next_pc,
    output logic [gps_cpu_isa_pkg::CODE_AW-1:0]  mem_addr,
    output logic                                 mem_we,
    output gps_cpu_io_pkg::half_t                mem_din,
    output logic                                 rd_reg,
    output logic                                 rd_bit,
    output logic                                 wr_reg,
    output logic                                 wr_evt,
    output logic                                 io_bank,
    output logic [gps_cpu_io_pkg::IO_SEL_W-1:0]  io_sel,
    output gps_cpu_io_pkg::word_t                io_data
);

    logic [7:0] op8;
    logic [3:0] op4;
    logic ret;
    logic call;
    logic jump;
    logic nz;
    logic serial;
    logic inc_sp;
    logic dec_sp;
    logic run;
    logic [gps_cpu_isa_pkg::CODE_AW-1:0] pc;
    logic [gps_cpu_isa_pkg::CODE_AW-1:0] pc_inc;
    gps_cpu_io_pkg::word_t next_tos;

    initial begin
        assert (STACK_AW >= 4 && STACK_AW <= 10)
            else $fatal(1, "STACK_AW must lie between 4 and 10");
    end

    ////////////////////////////////////////////////////////////////////////////
    // decode

    assign op8 = insn.alu.op8;
    assign op4 = insn.ctl.op4;
    // return bit only exists in the alu format
    assign ret = op8[7:5] == 3'b100 && insn.alu.ret;
    assign serial = ser[insn.alu.imm[6]];
    assign nz = |tos[15:0];
    assign call = op4 == gps_cpu_isa_pkg::op_jmp && !insn.ctl.cond;
    // bz when cond is 0, bnz when cond is 1
    assign jump = op4 == gps_cpu_isa_pkg::op_jmp
               || (op4 == gps_cpu_isa_pkg::op_brz && insn.ctl.cond == nz);

    always_comb begin
        inc_sp = !insn.lit.is_op || op4 == gps_cpu_isa_pkg::op_rd_reg;
        dec_sp = op4 == gps_cpu_isa_pkg::op_wr_reg || op4 == gps_cpu_isa_pkg::op_brz;
        case (op8)
            gps_cpu_isa_pkg::op_dup, gps_cpu_isa_pkg::op_over,
            gps_cpu_isa_pkg::op_r, gps_cpu_isa_pkg::op_r_from: inc_sp = 1'b1;
            gps_cpu_isa_pkg::op_drop, gps_cpu_isa_pkg::op_add,
            gps_cpu_isa_pkg::op_sub, gps_cpu_isa_pkg::op_mult,
            gps_cpu_isa_pkg::op_and, gps_cpu_isa_pkg::op_or,
            gps_cpu_isa_pkg::op_to_r, gps_cpu_isa_pkg::op_store16: dec_sp = 1'b1;
            default: ;
        endcase
    end

    // rot rewrites the entry under nos without moving sp
    assign dpush = inc_sp || op8 == gps_cpu_isa_pkg::op_rot;
    assign dpop = dec_sp || op8 == gps_cpu_isa_pkg::op_rot;
    assign rpush = call || op8 == gps_cpu_isa_pkg::op_to_r;
    assign rpop = ret || op8 == gps_cpu_isa_pkg::op_r_from;

    ////////////////////////////////////////////////////////////////////////////
    // program counter

    assign pc_inc = pc + 1'b1;
    // return addresses are kept as byte addresses
    assign rstk_din = call ? gps_cpu_io_pkg::word_t'({pc_inc, 1'b0}) : tos;

    always_comb begin
        if (!run) begin
            // first cycle after load or reset fetches word 0
            next_pc = '0;
        end else if (ret) begin
            next_pc = rstk_top[gps_cpu_isa_pkg::CODE_AW:1];
        end else if (jump) begin
            next_pc = insn.ctl.dest;
        end else begin
            next_pc = pc_inc;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
            run <= 1'b0;
        end else begin
            pc <= next_pc;
            run <= !load;
        end
    end

    assign alu_en = run;

    ////////////////////////////////////////////////////////////////////////////
    // top and next of stack

    always_comb begin
        case (op4)
            gps_cpu_isa_pkg::op_brz,
            gps_cpu_isa_pkg::op_wr_reg: next_tos = nos;
            gps_cpu_isa_pkg::op_rd_reg: next_tos = gps_cpu_io_pkg::word_t'(par);
            default: begin
                case (op8)
                    gps_cpu_isa_pkg::op_swap, gps_cpu_isa_pkg::op_over,
                    gps_cpu_isa_pkg::op_drop, gps_cpu_isa_pkg::op_to_r: next_tos = nos;
                    gps_cpu_isa_pkg::op_rot: next_tos = dstk_top;
                    gps_cpu_isa_pkg::op_r, gps_cpu_isa_pkg::op_r_from: next_tos = rstk_top;
                    // serial bit shifts in at the bottom
                    gps_cpu_isa_pkg::op_rd_bit: next_tos = {tos[30:0], serial};
                    gps_cpu_isa_pkg::op_fetch16:
                        next_tos = gps_cpu_io_pkg::word_t'(mem_dout);
                    default: next_tos = alu_result;
                endcase
            end
        endcase
    end

    always_ff @(posedge clk) begin
        tos <= next_tos;
        if (dpush) begin
            nos <= tos;
        end else if (dec_sp || op8 == gps_cpu_isa_pkg::op_swap) begin
            nos <= (op8 == gps_cpu_isa_pkg::op_swap) ? tos : dstk_top;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // memory port and I/O

    assign mem_rd = op8 == gps_cpu_isa_pkg::op_store16;
    assign mem_we = op8 == gps_cpu_isa_pkg::op_store16;
    assign mem_din = nos[15:0];
    // store writes at tos, reads are set up one cycle ahead
    assign mem_addr = mem_we ? tos[gps_cpu_isa_pkg::CODE_AW:1]
                             : next_tos[gps_cpu_isa_pkg::CODE_AW:1];

    assign rd_reg = op4 == gps_cpu_isa_pkg::op_rd_reg;
    assign wr_reg = op4 == gps_cpu_isa_pkg::op_wr_reg;
    assign wr_evt = op4 == gps_cpu_isa_pkg::op_wr_evt;
    assign rd_bit = op8 == gps_cpu_isa_pkg::op_rd_bit;
    assign io_bank = rd_bit ? insn.alu.imm[6] : insn.io.bank;
    assign io_sel = insn.io.sel;
    assign io_data = tos;

    a_one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        (rd_reg || rd_bit || wr_reg || wr_evt)
            |-> run && $onehot0({rd_reg, rd_bit, wr_reg, wr_evt}))
        else $error("I/O strobes overlap or fire outside the run phase");

endmodule

/* verilog/gps_cpu_code_ram.sv */
// gps_cpu code and data RAM, loaded one word per cycle from par during boot
`timescale 1ns/1ps

module gps_cpu_code_ram (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 load,
    input  gps_cpu_io_pkg::half_t                par,
    input  logic [gps_cpu_isa_pkg::CODE_AW-1:0]  next_pc,
    input  logic [gps_cpu_isa_pkg::CODE_AW-1:0]  mem_addr,
    input  logic                                 mem_we,
    input  gps_cpu_io_pkg::half_t                mem_din,
    output gps_cpu_isa_pkg::insn_t               insn,
    output gps_cpu_io_pkg::half_t                mem_dout
);

    gps_cpu_io_pkg::half_t ram [2 ** gps_cpu_isa_pkg::CODE_AW];
    logic [gps_cpu_isa_pkg::CODE_AW-1:0] load_cnt;
    logic [gps_cpu_isa_pkg::CODE_AW-1:0] addr_a;

    // port A: boot writes, otherwise instruction fetch
    assign addr_a = load ? load_cnt : next_pc;

    // restarts at 0 for every load phase
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_cnt <= '0;
        end else begin
            load_cnt <= load ? load_cnt + 1'b1 : '0;
        end
    end

    // stores never overlap the load, so one write path serves both ports
    always_ff @(posedge clk) begin
        if (load) begin
            ram[addr_a] <= par;
        end else if (mem_we) begin
            ram[mem_addr] <= mem_din;
        end
        mem_dout <= ram[mem_addr];
    end

    // nop until the first fetch after load
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            insn <= gps_cpu_isa_pkg::insn_t'(gps_cpu_isa_pkg::nop_word);
        end else if (load) begin
            insn <= gps_cpu_isa_pkg::insn_t'(gps_cpu_isa_pkg::nop_word);
        end else begin
            insn <= ram[addr_a];
        end
    end

    a_no_store_in_load: assert property (@(posedge clk) disable iff (!arst_n)
        load |-> !mem_we)
        else $error("store16 while the code RAM is being loaded");

endmodule

/* verilog/gps_cpu_stacks.sv */
// gps_cpu data and return stacks sharing one dual-port RAM, with their pointers
`timescale 1ns/1ps

module gps_cpu_stacks #(
    parameter int STACK_AW = 8
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  dpush,
    input  logic                  dpop,
    input  logic                  rpush,
    input  logic                  rpop,
    input  gps_cpu_io_pkg::word_t dstk_din,
    input  gps_cpu_io_pkg::word_t rstk_din,
    output gps_cpu_io_pkg::word_t dstk_top,
    output gps_cpu_io_pkg::word_t rstk_top
);

    // data stack in the low half, return stack in the high half
    localparam int DEPTH = 2 ** (STACK_AW + 1);

    gps_cpu_io_pkg::word_t ram [DEPTH];
    logic [STACK_AW-1:0] sp;
    logic [STACK_AW-1:0] rp;
    logic [STACK_AW-1:0] sp_next;
    logic [STACK_AW-1:0] rp_next;

    // push and pop together rewrite the top entry in place (rot)
    assign sp_next = sp + STACK_AW'(dpush) - STACK_AW'(dpop);
    assign rp_next = rp + STACK_AW'(rpush) - STACK_AW'(rpop);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sp <= '0;
            rp <= '0;
        end else begin
            sp <= sp_next;
            rp <= rp_next;
        end
    end

    // read at the next pointer, new data bypassed on a push
    always_ff @(posedge clk) begin
        if (dpush) begin
            ram[{1'b0, sp_next}] <= dstk_din;
        end
        if (rpush) begin
            ram[{1'b1, rp_next}] <= rstk_din;
        end
        dstk_top <= dpush ? dstk_din : ram[{1'b0, sp_next}];
        rstk_top <= rpush ? rstk_din : ram[{1'b1, rp_next}];
    end

    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
        !(dpop && !dpush && sp == '0) && !(rpop && !rpush && rp == '0))
        else $error("stack pop below the bottom entry");

    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        !(dpush && !dpop && sp == '1) && !(rpush && !rpop && rp == '1))
        else $error("stack push beyond the last entry");

endmodule

/* verilog/gps_cpu_alu.sv */
// gps_cpu ALU: 32-bit adder with carry, signed 16x16 multiply, logic ops and shifts
`timescale 1ns/1ps

module gps_cpu_alu (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   alu_en,
    input  gps_cpu_isa_pkg::insn_t insn,
    input  gps_cpu_io_pkg::word_t  tos,
    input  gps_cpu_io_pkg::word_t  nos,
    input  logic                   mem_rd,
    output gps_cpu_io_pkg::word_t  alu_result
);

    logic [7:0] op8;
    logic carry;
    logic cin;
    logic cout;
    gps_cpu_io_pkg::word_t a;
    gps_cpu_io_pkg::word_t b;
    gps_cpu_io_pkg::word_t sum;
    logic signed [31:0] prod;

    assign op8 = insn.alu.op8;

    ////////////////////////////////////////////////////////////////////////////
    // adder

    // sub is nos + ~tos + 1
    assign cin = (op8 == gps_cpu_isa_pkg::op_add && insn.alu.imm[6] && carry)
               || op8 == gps_cpu_isa_pkg::op_sub;

    always_comb begin
        if (op8 == gps_cpu_isa_pkg::op_addi) begin
            a = gps_cpu_io_pkg::word_t'(insn.alu.imm);
        end else if (mem_rd) begin
            // step to the next half-word
            a = 32'd2;
        end else begin
            a = nos;
        end
        b = (op8 == gps_cpu_isa_pkg::op_sub) ? ~tos : tos;
    end

    assign {cout, sum} = {1'b0, a} + {1'b0, b} + 33'(cin);

    // carry out of the last add, for multi-word sums
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            carry <= 1'b0;
        end else if (alu_en && op8 == gps_cpu_isa_pkg::op_add) begin
            carry <= cout;
        end
    end

    // low halves only, sign extended to 32 bits
    assign prod = $signed(nos[15:0]) * $signed(tos[15:0]);

    ////////////////////////////////////////////////////////////////////////////
    // result select

    always_comb begin
        if (!insn.lit.is_op) begin
            alu_result = gps_cpu_io_pkg::word_t'(insn.lit.value);
        end else if (mem_rd) begin
            alu_result = sum;
        end else begin
            case (op8)
                gps_cpu_isa_pkg::op_add,
                gps_cpu_isa_pkg::op_addi,
                gps_cpu_isa_pkg::op_sub:    alu_result = sum;
                gps_cpu_isa_pkg::op_mult:   alu_result = prod;
                gps_cpu_isa_pkg::op_and:    alu_result = nos & tos;
                gps_cpu_isa_pkg::op_or:     alu_result = nos | tos;
                gps_cpu_isa_pkg::op_not:    alu_result = ~tos;
                gps_cpu_isa_pkg::op_shl:    alu_result = {tos[30:0], 1'b0};
                // arithmetic, keeps the sign
                gps_cpu_isa_pkg::op_shr:    alu_result = {tos[31], tos[31:1]};
                gps_cpu_isa_pkg::op_swap16: alu_result = {tos[15:0], tos[31:16]};
                default:                    alu_result = tos;
            endcase
        end
    end

endmodule

/* verilog/gps_cpu_isa_pkg.sv */
// gps_cpu instruction set: opcodes, field widths and the four instruction word formats
package gps_cpu_isa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // field widths

    // code word address, also the branch destination field
    localparam int CODE_AW = 11;
    localparam int LIT_W = 15;
    localparam int IMM_W = 7;

    // word layouts, bit 15 on the left
    //   0vvv vvvv vvvv vvvv  push literal 0..0x7fff
    //   100o oooo Riii iiii  alu op, R = return, i = imm or carry/serial select
    //   101c dddd dddd ddd b  c=0 call/branch, c=1 bz/bnz, b = condition
    //   11oo kddd dddd dddd  rd_reg / wr_reg / wr_evt, k = bank
    typedef union packed {
        struct packed {
            logic is_op;
            logic [LIT_W-1:0] value;
        } lit;
        struct packed {
            logic [7:0] op8;
            logic ret;
            logic [IMM_W-1:0] imm;
        } alu;
        struct packed {
            logic [3:0] op4;
            logic [CODE_AW-1:0] dest;
            logic cond;
        } ctl;
        struct packed {
            logic [3:0] op4;
            logic bank;
            logic [gps_cpu_io_pkg::IO_SEL_W-1:0] sel;
        } io;
    } insn_t;

    ////////////////////////////////////////////////////////////////////////////
    // opcodes

    localparam logic [15:0] nop_word = 16'h8000;

    localparam logic [7:0] op_dup = 8'h81;
    localparam logic [7:0] op_swap = 8'h82;
    localparam logic [7:0] op_swap16 = 8'h83;
    localparam logic [7:0] op_over = 8'h84;
    localparam logic [7:0] op_drop = 8'h85;
    localparam logic [7:0] op_rot = 8'h86;
    // imm field is the operand
    localparam logic [7:0] op_addi = 8'h87;
    // imm[6] chains the carry
    localparam logic [7:0] op_add = 8'h88;
    localparam logic [7:0] op_sub = 8'h89;
    localparam logic [7:0] op_mult = 8'h8a;
    localparam logic [7:0] op_and = 8'h8b;
    localparam logic [7:0] op_or = 8'h8c;
    localparam logic [7:0] op_not = 8'h8e;
    localparam logic [7:0] op_shl = 8'h91;
    localparam logic [7:0] op_shr = 8'h92;
    // imm[6] picks the serial input
    localparam logic [7:0] op_rd_bit = 8'h93;
    localparam logic [7:0] op_fetch16 = 8'h94;
    // ( d a -- a+2 )
    localparam logic [7:0] op_store16 = 8'h95;
    localparam logic [7:0] op_r = 8'h9c;
    localparam logic [7:0] op_r_from = 8'h9d;
    localparam logic [7:0] op_to_r = 8'h9e;

    localparam logic [3:0] op_jmp = 4'ha;
    localparam logic [3:0] op_brz = 4'hb;
    localparam logic [3:0] op_rd_reg = 4'hc;
    localparam logic [3:0] op_wr_reg = 4'hd;
    localparam logic [3:0] op_wr_evt = 4'he;

endpackage

/* verilog/gps_cpu_io_pkg.sv */
// gps_cpu data words and the I/O select space seen by the receiver logic
package gps_cpu_io_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // data words

    // stack entries, tos and nos
    typedef logic [31:0] word_t;

    // code/data memory words and the par bus
    typedef logic [15:0] half_t;

    ////////////////////////////////////////////////////////////////////////////
    // I/O selects

    // each bank decodes its own set of selects
    localparam int IO_SEL_W = 11;

endpackage
